// ==== design/gps_pkg.sv ====
`default_nettype none

package gps_pkg;

    // Satellite number, legal range 1 to 32
    typedef logic [5:0] prn_t;

    // Two G2 stage numbers (1 to 10) whose XOR gives the delayed G2 output
    typedef struct packed {
        logic [3:0] tap_a;
        logic [3:0] tap_b;
    } g2_taps_t;

    // ********************
    // IS-GPS-200 phase selector pairs, indexed by PRN-1
    // ********************
    parameter g2_taps_t G2_TAP_TABLE [0:31] = '{
        // PRN 1 to 8
        '{4'd2, 4'd6}, '{4'd3, 4'd7}, '{4'd4, 4'd8}, '{4'd5, 4'd9},
        '{4'd1, 4'd9}, '{4'd2, 4'd10}, '{4'd1, 4'd8}, '{4'd2, 4'd9},
        // PRN 9 to 16
        '{4'd3, 4'd10}, '{4'd2, 4'd3}, '{4'd3, 4'd4}, '{4'd5, 4'd6},
        '{4'd6, 4'd7}, '{4'd7, 4'd8}, '{4'd8, 4'd9}, '{4'd9, 4'd10},
        // PRN 17 to 24
        '{4'd1, 4'd4}, '{4'd2, 4'd5}, '{4'd3, 4'd6}, '{4'd4, 4'd7},
        '{4'd5, 4'd8}, '{4'd6, 4'd9}, '{4'd1, 4'd3}, '{4'd4, 4'd6},
        // PRN 25 to 32
        '{4'd5, 4'd7}, '{4'd6, 4'd8}, '{4'd7, 4'd9}, '{4'd8, 4'd10},
        '{4'd1, 4'd6}, '{4'd2, 4'd7}, '{4'd3, 4'd8}, '{4'd4, 4'd9}
    };

    // Chips in one C/A code period
    parameter int CA_CODE_LEN = 1023;

    // Fast clocks per chip, 10.23 MHz down to 1.023 MHz
    parameter int DEF_CHIP_DIV = 10;

    // Chips packed into one output word
    parameter int DEF_WORD_CHIPS = 32;

endpackage

`default_nettype wire

// ==== design/gps_chip_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface gps_chip_if;

    // One cycle per chip, no back-pressure
    logic chip_valid;
    // Chip value
    logic chip;
    // Marks chip index 0 of the code period
    logic epoch;
    // First chip of a newly selected PRN
    logic restart;

    // ********************
    // Code generator side
    // ********************
    modport gen (
        output chip_valid,
        output chip,
        output epoch,
        output restart
    );

    // ********************
    // Word packer side
    // ********************
    modport pack (
        input  chip_valid,
        input  chip,
        input  epoch,
        input  restart
    );

endinterface

`default_nettype wire

// ==== design/gps_chip_strobe.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_chip_strobe #(
    parameter int CHIP_DIV = gps_pkg::DEF_CHIP_DIV
) (
    input  logic gps_clk_fast,
    input  logic rst_n,
    output logic chip_stb
);

    localparam int CNT_W = $clog2(CHIP_DIV);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CHIP_DIV - 1);

    logic [CNT_W-1:0] div_cnt;

    // Free running divider, one strobe per chip period
    always_ff @(posedge gps_clk_fast or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_cnt  <= '0;
            chip_stb <= 1'b0;
        end
        else
        begin
            if (div_cnt == CNT_LAST)
            begin
                div_cnt  <= '0;
                chip_stb <= 1'b1;
            end
            else
            begin
                div_cnt  <= div_cnt + 1'b1;
                chip_stb <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/gps_prn_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_prn_select (
    input  logic          gps_clk_fast,
    input  logic          rst_n,
    input  logic          chip_stb,
    input  logic          prn_req,
    input  gps_pkg::prn_t prn_sel,
    output logic          prn_ack,
    output logic          prn_new,
    output gps_pkg::prn_t prn_cur
);

    localparam int PRN_MAX = 32;

    typedef enum logic {
        PS_IDLE,
        PS_ACK
    } ps_state_t;

    ps_state_t ps_state;
    logic      prn_legal;
    logic      accept;

    // ********************
    // Host request decode
    // ********************
    assign prn_legal = (prn_sel != '0) && (prn_sel <= gps_pkg::prn_t'(PRN_MAX));

    // Illegal numbers still get the handshake, just no latch
    assign accept = (ps_state == PS_IDLE) && prn_req && prn_legal;

    assign prn_ack = (ps_state == PS_ACK);

    // Four-phase acknowledge
    always_ff @(posedge gps_clk_fast or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ps_state <= PS_IDLE;
        end
        else
        begin
            case (ps_state)
                PS_IDLE:
                begin
                    if (prn_req)
                        ps_state <= PS_ACK;
                end
                PS_ACK:
                begin
                    if (!prn_req)
                        ps_state <= PS_IDLE;
                end
                default: ps_state <= PS_IDLE;
            endcase
        end
    end

    // Pending flag, taken by the generator on its next strobe
    // A fresh accept wins over a strobe in the same cycle
    always_ff @(posedge gps_clk_fast or negedge rst_n)
    begin
        if (!rst_n)
            prn_new <= 1'b0;
        else if (accept)
            prn_new <= 1'b1;
        else if (chip_stb)
            prn_new <= 1'b0;
    end

    always_ff @(posedge gps_clk_fast)
    begin
        if (accept)
            prn_cur <= prn_sel;
    end

endmodule

`default_nettype wire

// ==== design/gps_ca_code_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_ca_code_gen (
    input  logic          gps_clk_fast,
    input  logic          rst_n,
    input  logic          chip_stb,
    input  logic          prn_new,
    input  gps_pkg::prn_t prn_cur,
    gps_chip_if.gen       chip_out
);

    localparam logic [9:0]  LAST_IDX = 10'(gps_pkg::CA_CODE_LEN - 1);
    localparam logic [10:1] ALL_ONES = '1;

    // Shift registers, stage 1 takes the feedback
    logic [10:1]       g1;
    logic [10:1]       g2;
    logic [9:0]        chip_idx;
    logic              running;
    logic [4:0]        tap_idx;
    gps_pkg::g2_taps_t taps;
    logic [10:1]       g1_src;
    logic [10:1]       g2_src;
    logic              chip_nxt;
    logic              advance;

    // ********************
    // LFSR steps
    // ********************

    // G1 = 1 + x^3 + x^10
    function automatic logic [10:1] g1_step(input logic [10:1] g);
        return {g[9:1], g[3] ^ g[10]};
    endfunction

    // G2 = 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10
    function automatic logic [10:1] g2_step(input logic [10:1] g);
        logic fb;
        fb = g[2] ^ g[3] ^ g[6] ^ g[8] ^ g[9] ^ g[10];
        return {g[9:1], fb};
    endfunction

    // Phase selector taps for the current satellite
    assign tap_idx = 5'(prn_cur - 6'd1);
    assign taps    = gps_pkg::G2_TAP_TABLE[tap_idx];

    // A restart produces chip 0 straight from the all-ones load
    assign g1_src   = prn_new ? ALL_ONES : g1;
    assign g2_src   = prn_new ? ALL_ONES : g2;
    assign chip_nxt = g1_src[10] ^ g2_src[taps.tap_a] ^ g2_src[taps.tap_b];

    assign advance = chip_stb && (prn_new || running);

    // ********************
    // Chip timing and flags
    // ********************
    always_ff @(posedge gps_clk_fast or negedge rst_n)
    begin
        if (!rst_n)
        begin
            running             <= 1'b0;
            chip_idx            <= '0;
            chip_out.chip_valid <= 1'b0;
            chip_out.epoch      <= 1'b0;
            chip_out.restart    <= 1'b0;
        end
        else
        begin
            chip_out.chip_valid <= 1'b0;
            chip_out.epoch      <= 1'b0;
            chip_out.restart    <= 1'b0;

            if (chip_stb && prn_new)
            begin
                running             <= 1'b1;
                chip_idx            <= 10'd1;
                chip_out.chip_valid <= 1'b1;
                chip_out.epoch      <= 1'b1;
                chip_out.restart    <= 1'b1;
            end
            else if (chip_stb && running)
            begin
                chip_out.chip_valid <= 1'b1;
                chip_out.epoch      <= (chip_idx == '0);
                // Index wraps after chip 1022, registers are back at all ones
                if (chip_idx == LAST_IDX)
                    chip_idx <= '0;
                else
                    chip_idx <= chip_idx + 10'd1;
            end
        end
    end

    // Register contents and chip value
    always_ff @(posedge gps_clk_fast)
    begin
        if (advance)
        begin
            g1            <= g1_step(g1_src);
            g2            <= g2_step(g2_src);
            chip_out.chip <= chip_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== design/gps_chip_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_chip_packer #(
    parameter int WORD_CHIPS = gps_pkg::DEF_WORD_CHIPS
) (
    input  logic                  gps_clk_fast,
    input  logic                  rst_n,
    gps_chip_if.pack              chip_in,
    output logic                  word_req,
    input  logic                  word_ack,
    output logic [WORD_CHIPS-1:0] word_data,
    output logic                  word_epoch,
    output logic                  overflow
);

    localparam int FILL_W = $clog2(WORD_CHIPS);
    localparam logic [FILL_W-1:0] FILL_LAST = FILL_W'(WORD_CHIPS - 1);

    // EMPTY: nothing held, PEND: held but ack still high, REQ: word offered
    typedef enum logic [1:0] {
        HS_EMPTY,
        HS_PEND,
        HS_REQ
    } hs_state_t;

    hs_state_t             hs_state;
    logic [WORD_CHIPS-1:0] shift_q;
    logic [FILL_W-1:0]     fill_cnt;
    logic                  part_epoch;
    logic [WORD_CHIPS-1:0] hold_data;
    logic                  hold_epoch;
    logic [WORD_CHIPS-1:0] word_next;
    logic                  epoch_next;
    logic                  word_done;
    logic                  hold_free;
    logic                  load;

    // ********************
    // Word assembly
    // ********************

    // MSB first, newest chip enters at bit 0
    assign word_next  = {shift_q[WORD_CHIPS-2:0], chip_in.chip};
    assign epoch_next = part_epoch | chip_in.epoch;
    assign word_done  = chip_in.chip_valid && !chip_in.restart && (fill_cnt == FILL_LAST);

    // Holding word frees up in the same cycle it is acknowledged
    assign hold_free = (hs_state == HS_EMPTY) || ((hs_state == HS_REQ) && word_ack);
    assign load      = word_done && hold_free;

    always_ff @(posedge gps_clk_fast or negedge rst_n)
    begin
        if (!rst_n)
        begin
            fill_cnt   <= '0;
            part_epoch <= 1'b0;
        end
        else if (chip_in.chip_valid)
        begin
            if (chip_in.restart)
            begin
                // Partial word dropped, restart chip opens a new one
                fill_cnt   <= FILL_W'(1);
                part_epoch <= chip_in.epoch;
            end
            else if (fill_cnt == FILL_LAST)
            begin
                fill_cnt   <= '0;
                part_epoch <= 1'b0;
            end
            else
            begin
                fill_cnt   <= fill_cnt + 1'b1;
                part_epoch <= epoch_next;
            end
        end
    end

    always_ff @(posedge gps_clk_fast)
    begin
        if (chip_in.chip_valid)
            shift_q <= word_next;
        if (load)
        begin
            hold_data  <= word_next;
            hold_epoch <= epoch_next;
        end
    end

    // ********************
    // Output handshake
    // ********************
    always_ff @(posedge gps_clk_fast or negedge rst_n)
    begin
        if (!rst_n)
        begin
            hs_state <= HS_EMPTY;
            overflow <= 1'b0;
        end
        else
        begin
            case (hs_state)
                HS_EMPTY:
                begin
                    if (load)
                        hs_state <= word_ack ? HS_PEND : HS_REQ;
                end
                HS_PEND:
                begin
                    if (!word_ack)
                        hs_state <= HS_REQ;
                end
                HS_REQ:
                begin
                    if (word_ack)
                        hs_state <= load ? HS_PEND : HS_EMPTY;
                end
                default: hs_state <= HS_EMPTY;
            endcase

            // Sticky until reset
            if (word_done && !hold_free)
                overflow <= 1'b1;
        end
    end

    assign word_req   = (hs_state == HS_REQ);
    assign word_data  = hold_data;
    assign word_epoch = hold_epoch;

endmodule

`default_nettype wire

// ==== design/gps_code_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_code_top #(
    parameter int CHIP_DIV   = gps_pkg::DEF_CHIP_DIV,
    parameter int WORD_CHIPS = gps_pkg::DEF_WORD_CHIPS
) (
    input  logic                  gps_clk_fast,
    input  logic                  rst_n,
    input  logic                  prn_req,
    input  gps_pkg::prn_t         prn_sel,
    output logic                  prn_ack,
    output logic                  word_req,
    input  logic                  word_ack,
    output logic [WORD_CHIPS-1:0] word_data,
    output logic                  word_epoch,
    output logic                  overflow
);

    logic          chip_stb;
    logic          prn_new;
    gps_pkg::prn_t prn_cur;

    // Chip stream from generator to packer
    gps_chip_if chip_if_i ();

    gps_chip_strobe #(
        .CHIP_DIV (CHIP_DIV)
    ) strobe_i (
        .gps_clk_fast (gps_clk_fast),
        .rst_n        (rst_n),
        .chip_stb     (chip_stb)
    );

    gps_prn_select prn_sel_i (
        .gps_clk_fast (gps_clk_fast),
        .rst_n        (rst_n),
        .chip_stb     (chip_stb),
        .prn_req      (prn_req),
        .prn_sel      (prn_sel),
        .prn_ack      (prn_ack),
        .prn_new      (prn_new),
        .prn_cur      (prn_cur)
    );

    gps_ca_code_gen code_gen_i (
        .gps_clk_fast (gps_clk_fast),
        .rst_n        (rst_n),
        .chip_stb     (chip_stb),
        .prn_new      (prn_new),
        .prn_cur      (prn_cur),
        .chip_out     (chip_if_i.gen)
    );

    gps_chip_packer #(
        .WORD_CHIPS (WORD_CHIPS)
    ) packer_i (
        .gps_clk_fast (gps_clk_fast),
        .rst_n        (rst_n),
        .chip_in      (chip_if_i.pack),
        .word_req     (word_req),
        .word_ack     (word_ack),
        .word_data    (word_data),
        .word_epoch   (word_epoch),
        .overflow     (overflow)
    );

endmodule

`default_nettype wire

// ==== dv/gps_code_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_code_sva #(
    parameter int WORD_CHIPS = gps_pkg::DEF_WORD_CHIPS
) (
    input logic                  gps_clk_fast,
    input logic                  rst_n,
    input logic                  prn_req,
    input logic                  prn_ack,
    input logic                  word_req,
    input logic                  word_ack,
    input logic [WORD_CHIPS-1:0] word_data,
    input logic                  word_epoch
);

    // Read by the testbench at the end of the run
    int fail_cnt = 0;

    // ********************
    // Output port
    // ********************
    word_hold_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (word_req && !word_ack) |=> (word_req && $stable(word_data) && $stable(word_epoch)))
    else
    begin
        $error("word_req or its payload changed before word_ack");
        fail_cnt++;
    end

    word_drop_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (word_req && word_ack) |=> !word_req)
    else
    begin
        $error("word_req still high the clock after word_ack");
        fail_cnt++;
    end

    // The clock that raised word_req must have seen word_ack low
    word_rise_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        $rose(word_req) |-> !$past(word_ack))
    else
    begin
        $error("word_req rose while word_ack was high");
        fail_cnt++;
    end

    // ********************
    // Host port
    // ********************
    prn_rise_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        $rose(prn_ack) |-> $past(prn_req))
    else
    begin
        $error("prn_ack rose without a prior prn_req");
        fail_cnt++;
    end

    prn_hold_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (prn_ack && prn_req) |=> prn_ack)
    else
    begin
        $error("prn_ack fell while prn_req was still high");
        fail_cnt++;
    end

    prn_fall_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (prn_ack && !prn_req) |=> !prn_ack)
    else
    begin
        $error("prn_ack did not fall one clock after prn_req");
        fail_cnt++;
    end

endmodule

bind gps_code_top gps_code_sva #(
    .WORD_CHIPS (WORD_CHIPS)
) sva_i (
    .gps_clk_fast (gps_clk_fast),
    .rst_n        (rst_n),
    .prn_req      (prn_req),
    .prn_ack      (prn_ack),
    .word_req     (word_req),
    .word_ack     (word_ack),
    .word_data    (word_data),
    .word_epoch   (word_epoch)
);

`default_nettype wire

// ==== dv/gps_code_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gps_code_tb;

    localparam int CHIP_DIV    = 10;
    localparam int WORD_CHIPS  = 32;
    localparam int WORD_CLKS   = CHIP_DIV * WORD_CHIPS;
    localparam int RUN_WORDS   = 33;
    localparam int CYCLE_LIMIT = 8 * RUN_WORDS * WORD_CLKS + 2000;

    logic                  gps_clk_fast;
    logic                  rst_n;
    logic                  prn_req;
    gps_pkg::prn_t         prn_sel;
    logic                  prn_ack;
    logic                  word_req;
    logic                  word_ack;
    logic [WORD_CHIPS-1:0] word_data;
    logic                  word_epoch;
    logic                  overflow;

    // Reference model state
    logic [10:1]           m_g1;
    logic [10:1]           m_g2;
    gps_pkg::g2_taps_t     m_taps;
    int                    m_idx;
    logic [WORD_CHIPS-1:0] exp_data;
    logic                  exp_epoch;

    // Test control
    logic check_en;
    logic hold_ack;
    logic ovf_armed;
    logic ovf_expect;
    logic first_prn1;
    int   words_done;
    int   data_errs = 0;
    int   epoch_errs = 0;
    int   flag_errs = 0;
    int   proto_errs;
    int   cycle_cnt = 0;
    int   seed_val;

    gps_code_top #(
        .CHIP_DIV   (CHIP_DIV),
        .WORD_CHIPS (WORD_CHIPS)
    ) gps_code_top_i (
        .gps_clk_fast (gps_clk_fast),
        .rst_n        (rst_n),
        .prn_req      (prn_req),
        .prn_sel      (prn_sel),
        .prn_ack      (prn_ack),
        .word_req     (word_req),
        .word_ack     (word_ack),
        .word_data    (word_data),
        .word_epoch   (word_epoch),
        .overflow     (overflow)
    );

    initial gps_clk_fast = 1'b0;
    always #4 gps_clk_fast = ~gps_clk_fast;

    // ********************
    // Reference model
    // ********************

    // Next 32 chips, MSB first, from the G1/G2 code rule
    task automatic build_word();
        logic c;
        exp_epoch = 1'b0;
        for (int i = 0; i < WORD_CHIPS; i++)
        begin
            c = m_g1[10] ^ m_g2[m_taps.tap_a] ^ m_g2[m_taps.tap_b];
            exp_data = {exp_data[WORD_CHIPS-2:0], c};
            if (m_idx == 0)
                exp_epoch = 1'b1;
            m_g1 = {m_g1[9:1], m_g1[3] ^ m_g1[10]};
            m_g2 = {m_g2[9:1], m_g2[2] ^ m_g2[3] ^ m_g2[6] ^ m_g2[8] ^ m_g2[9] ^ m_g2[10]};
            m_idx = (m_idx == gps_pkg::CA_CODE_LEN - 1) ? 0 : m_idx + 1;
        end
    endtask

    task automatic restart_model(input gps_pkg::prn_t prn);
        m_g1   = '1;
        m_g2   = '1;
        m_idx  = 0;
        m_taps = gps_pkg::G2_TAP_TABLE[5'(prn - 6'd1)];
        build_word();
    endtask

    // ********************
    // Host and sink
    // ********************
    task automatic select_prn(input gps_pkg::prn_t prn);
        prn_sel = prn;
        prn_req = 1'b1;
        while (!prn_ack)
            @(negedge gps_clk_fast);
        // Request stays up a few clocks past the ack
        repeat ($urandom_range(3, 1)) @(negedge gps_clk_fast);
        prn_req = 1'b0;
        while (prn_ack)
            @(negedge gps_clk_fast);
        // Out of range numbers leave the running code alone
        if (prn >= 6'd1 && prn <= 6'd32)
            restart_model(prn);
    endtask

    task automatic wait_words(input int n);
        int target;
        target = words_done + n;
        while (words_done < target)
            @(negedge gps_clk_fast);
    endtask

    task automatic wait_mid_word();
        repeat ($urandom_range(150, 20)) @(negedge gps_clk_fast);
    endtask

    // Word sink with a random ack delay
    initial
    begin
        forever
        begin
            @(negedge gps_clk_fast);
            if (rst_n && word_req && !word_ack && !hold_ack)
            begin
                repeat ($urandom_range(3, 0)) @(negedge gps_clk_fast);
                word_ack = 1'b1;
                while (word_req)
                    @(negedge gps_clk_fast);
                word_ack   = 1'b0;
                first_prn1 = 1'b0;
                build_word();
                words_done++;
            end
        end
    end

    // ********************
    // Checks
    // ********************
    data_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (word_req && check_en) |-> (word_data == exp_data))
    else
    begin
        data_errs++;
        $display("Error: word_data expected %h actual %h", exp_data, word_data);
    end

    epoch_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (word_req && check_en) |-> (word_epoch == exp_epoch))
    else
    begin
        epoch_errs++;
        $display("Error: word_epoch expected %h actual %h", exp_epoch, word_epoch);
    end

    // PRN 1 opens with octal 1440
    prn1_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        (word_req && first_prn1) |-> (word_data[WORD_CHIPS-1 -: 10] == 10'o1440) && word_epoch)
    else
    begin
        data_errs++;
        $display("Error: word_data[31:22] expected %h actual %h",
                 10'o1440, word_data[WORD_CHIPS-1 -: 10]);
    end

    ovf_low_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        !ovf_armed |-> !overflow)
    else
    begin
        flag_errs++;
        $display("Error: overflow expected %h actual %h", 1'b0, overflow);
    end

    ovf_set_a: assert property (@(posedge gps_clk_fast) disable iff (!rst_n)
        ovf_expect |-> overflow)
    else
    begin
        flag_errs++;
        $display("Error: overflow expected %h actual %h", 1'b1, overflow);
    end

    reset_a: assert property (@(posedge gps_clk_fast)
        $rose(rst_n) |-> (!prn_ack && !word_req && !overflow))
    else
    begin
        flag_errs++;
        $display("Outputs were not all low when reset was released");
    end

    always @(posedge gps_clk_fast)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // ********************
    // Stimulus
    // ********************
    initial
    begin
        seed_val   = $urandom(32'hef68);
        rst_n      = 1'b0;
        prn_req    = 1'b0;
        prn_sel    = '0;
        word_ack   = 1'b0;
        check_en   = 1'b0;
        hold_ack   = 1'b0;
        ovf_armed  = 1'b0;
        ovf_expect = 1'b0;
        first_prn1 = 1'b0;
        words_done = 0;
        repeat (16) @(negedge gps_clk_fast);
        rst_n = 1'b1;
        repeat (20) @(negedge gps_clk_fast);

        // PRN 1 over a full code period
        check_en   = 1'b1;
        first_prn1 = 1'b1;
        select_prn(6'd1);
        wait_words(RUN_WORDS);

        // Random satellites switched in part way through a word
        for (int n = 0; n < 4; n++)
        begin
            wait_mid_word();
            select_prn(6'($urandom_range(32, 1)));
            wait_words(RUN_WORDS);
        end
        for (int n = 0; n < 2; n++)
        begin
            wait_mid_word();
            select_prn(6'($urandom_range(32, 1)));
            wait_words(3);
        end

        // Illegal numbers are acked and the code keeps running
        wait_mid_word();
        select_prn(6'd0);
        wait_words(2);
        wait_mid_word();
        select_prn(6'd40);
        wait_words(2);

        // Stall the sink past two word times
        hold_ack  = 1'b1;
        ovf_armed = 1'b1;
        while (!word_req)
            @(negedge gps_clk_fast);
        repeat (WORD_CLKS * 5 / 2) @(negedge gps_clk_fast);
        ovf_expect = 1'b1;
        repeat (10) @(negedge gps_clk_fast);
        check_en = 1'b0;
        hold_ack = 1'b0;
        wait_words(2);
        repeat (20) @(negedge gps_clk_fast);

        proto_errs = gps_code_top_i.sva_i.fail_cnt;
        $display("Error counts: data %0d epoch %0d flag %0d protocol %0d",
                 data_errs, epoch_errs, flag_errs, proto_errs);
        if (data_errs + epoch_errs + flag_errs + proto_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/gps_pkg.sv
design/gps_chip_if.sv
design/gps_chip_strobe.sv
design/gps_prn_select.sv
design/gps_ca_code_gen.sv
design/gps_chip_packer.sv
design/gps_code_top.sv
dv/gps_code_sva.sv
dv/gps_code_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the C/A code testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module gps_code_tb \
    -Mdir obj_dir -o gps_code_sim || { echo "BUILD FAILED"; exit 1; }
sim_out="$(./obj_dir/gps_code_sim +verilator+error+limit+1000)"
echo "$sim_out"
echo "$sim_out" | grep -qx "sim passed" && echo "PASS" || { echo "FAIL"; exit 1; }
